// File: hw/div_pkg.sv
/*
  Shared widths, encodings and payload structs for the iterative divider.
  Structs are packed, first field in the most significant bits.
*/
`default_nettype none

package div_pkg;

  // ----------------------------------------
  // sizes and timing
  // ----------------------------------------
  localparam int unsigned data_w       = 32;
  localparam int unsigned step_count   = 32;
  localparam int unsigned cnt_w        = 6;
  // request edge to response valid, in cycles
  localparam int unsigned resp_latency = 34;

  // ----------------------------------------
  // encodings
  // ----------------------------------------
  typedef enum logic {
    div_fn_unsigned = 1'b0,
    div_fn_signed   = 1'b1
  } div_fn_e;

  typedef enum logic [2:0] {
    st_idle = 3'd0,
    st_load = 3'd1,
    st_calc = 3'd2,
    st_fix  = 3'd3,
    st_done = 3'd4
  } div_state_e;

  // ----------------------------------------
  // payloads
  // ----------------------------------------
  // 65 bits: fn, dividend, divisor
  typedef struct packed {
    div_fn_e           fn;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
  } div_req_t;

  // 64 bits: remainder on top, quotient below
  typedef struct packed {
    logic [data_w-1:0] rem;
    logic [data_w-1:0] quot;
  } div_resp_t;

  // 66 bits: magnitudes plus sign fix flags
  typedef struct packed {
    logic [data_w-1:0] a_mag;
    logic [data_w-1:0] b_mag;
    logic              neg_quot;
    logic              neg_rem;
  } div_operands_t;

endpackage

`default_nettype wire

// File: hw/div_ctrl.sv
/*
  Divider sequencer: idle, load, calc, fix, done.
  One division in flight; req_rdy only in idle, resp_val only in done.
*/
`timescale 1ns/100ps
`default_nettype none

module div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  input  logic last_step,
  output logic req_rdy,
  output logic resp_val,
  output logic capture,
  output logic load,
  output logic step,
  output logic fix
);

  div_pkg::div_state_e state_q;
  div_pkg::div_state_e state_d;

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      div_pkg::st_idle: begin
        // handshake edge captures operands
        if (req_val) begin
          state_d = div_pkg::st_load;
        end
      end
      div_pkg::st_load: begin
        state_d = div_pkg::st_calc;
      end
      div_pkg::st_calc: begin
        // counter flags the 32nd step
        if (last_step) begin
          state_d = div_pkg::st_fix;
        end
      end
      div_pkg::st_fix: begin
        state_d = div_pkg::st_done;
      end
      div_pkg::st_done: begin
        // hold response until consumer takes it
        if (resp_rdy) begin
          state_d = div_pkg::st_idle;
        end
      end
      default: begin
        state_d = div_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= div_pkg::st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------
  // handshake outputs and strobes
  // ----------------------------------------
  assign req_rdy  = (state_q == div_pkg::st_idle);
  assign resp_val = (state_q == div_pkg::st_done);

  // capture only on an actual transfer
  assign capture  = req_rdy && req_val;
  assign load     = (state_q == div_pkg::st_load);
  assign step     = (state_q == div_pkg::st_calc);
  assign fix      = (state_q == div_pkg::st_fix);

endmodule

`default_nettype wire

// File: hw/div_step_counter.sv
/*
  Counts shift-subtract steps; last_step marks the final one.
  Restarted by load before every division.
*/
`timescale 1ns/100ps
`default_nettype none

module div_step_counter (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  logic step,
  output logic last_step
);

  logic [div_pkg::cnt_w-1:0] count_q;

  // steps already applied in this division
  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
    end else if (load) begin
      count_q <= '0;
    end else if (step) begin
      count_q <= count_q + 1'b1;
    end
  end

  // high while the 32nd step is being applied
  assign last_step = step &&
                     (count_q == div_pkg::cnt_w'(div_pkg::step_count - 1));

endmodule

`default_nettype wire

// File: hw/div_operand_prep.sv
/*
  Registers operand magnitudes and sign fix flags on capture.
  Unsigned requests pass straight through with both flags clear.
*/
`timescale 1ns/100ps
`default_nettype none

module div_operand_prep (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  capture,
  input  div_pkg::div_req_t     req,
  output div_pkg::div_operands_t ops
);

  logic                       is_signed;
  logic                       a_neg;
  logic                       b_neg;
  logic [div_pkg::data_w-1:0] a_mag;
  logic [div_pkg::data_w-1:0] b_mag;
  div_pkg::div_operands_t     ops_d;

  // ----------------------------------------
  // magnitudes
  // ----------------------------------------
  assign is_signed = (req.fn == div_pkg::div_fn_signed);

  // sign bits only count in signed mode
  assign a_neg = is_signed && req.a[div_pkg::data_w-1];
  assign b_neg = is_signed && req.b[div_pkg::data_w-1];

  // two's complement negate
  // 0x80000000 maps to itself, read as unsigned
  assign a_mag = a_neg ? (~req.a + 1'b1) : req.a;
  assign b_mag = b_neg ? (~req.b + 1'b1) : req.b;

  // ----------------------------------------
  // flags and register
  // ----------------------------------------
  always_comb begin
    ops_d.a_mag    = a_mag;
    ops_d.b_mag    = b_mag;
    // quotient negative when exactly one operand is
    ops_d.neg_quot = a_neg ^ b_neg;
    // remainder follows the dividend
    ops_d.neg_rem  = a_neg;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ops <= '0;
    end else if (capture) begin
      ops <= ops_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/div_shift_sub.sv
/*
  Restoring shift-subtract core on magnitudes with one quotient bit per step.
  A zero divisor never borrows. Quotient ends all ones and remainder equals the dividend.
*/
`timescale 1ns/100ps
`default_nettype none

module div_shift_sub (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       load,
  input  logic                       step,
  input  div_pkg::div_operands_t     ops,
  output logic [div_pkg::data_w-1:0] quot_mag,
  output logic [div_pkg::data_w-1:0] rem_mag
);

  logic [div_pkg::data_w-1:0] rem_q;
  logic [div_pkg::data_w-1:0] quot_q;

  // shifted remainder with the quotient msb in the bottom
  logic [div_pkg::data_w:0]   rem_sh;
  logic [div_pkg::data_w:0]   diff;
  logic                       borrow;
  logic [div_pkg::data_w-1:0] rem_d;
  logic [div_pkg::data_w-1:0] quot_d;

  // ----------------------------------------
  // one step
  // ----------------------------------------
  assign rem_sh = {rem_q, quot_q[div_pkg::data_w-1]};

  // extra top bit catches the borrow
  // shifted remainder may exceed 32 bits
  assign {borrow, diff} = {1'b0, rem_sh} - {2'b00, ops.b_mag};

  always_comb begin
    if (borrow) begin
      // restore when the divisor did not fit
      rem_d  = rem_sh[div_pkg::data_w-1:0];
      quot_d = {quot_q[div_pkg::data_w-2:0], 1'b0};
    end else begin
      // no borrow means diff is below the divisor and fits in 32 bits
      rem_d  = diff[div_pkg::data_w-1:0];
      quot_d = {quot_q[div_pkg::data_w-2:0], 1'b1};
    end
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      rem_q  <= '0;
      quot_q <= '0;
    end else if (load) begin
      rem_q  <= '0;
      // dividend bits shift out of the top as quotient bits shift in
      quot_q <= ops.a_mag;
    end else if (step) begin
      rem_q  <= rem_d;
      quot_q <= quot_d;
    end
  end

  assign quot_mag = quot_q;
  assign rem_mag  = rem_q;

endmodule

`default_nettype wire

// File: hw/div_result_fix.sv
/*
  Sign correction of the magnitude result, registered on fix.
  resp holds until the next fix; only meaningful while resp_val is high.
*/
`timescale 1ns/100ps
`default_nettype none

module div_result_fix (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       fix,
  input  div_pkg::div_operands_t     ops,
  input  logic [div_pkg::data_w-1:0] quot_mag,
  input  logic [div_pkg::data_w-1:0] rem_mag,
  output div_pkg::div_resp_t         resp
);

  logic [div_pkg::data_w-1:0] quot_fixed;
  logic [div_pkg::data_w-1:0] rem_fixed;
  div_pkg::div_resp_t         resp_d;

  // ----------------------------------------
  // sign correction
  // ----------------------------------------
  // quotient truncates toward zero
  assign quot_fixed = ops.neg_quot ? (~quot_mag + 1'b1) : quot_mag;

  // remainder takes the dividend sign
  assign rem_fixed  = ops.neg_rem ? (~rem_mag + 1'b1) : rem_mag;

  always_comb begin
    resp_d.rem  = rem_fixed;
    resp_d.quot = quot_fixed;
  end

  // ----------------------------------------
  // response register
  // ----------------------------------------
  // stays put through back-pressure in done
  always_ff @(posedge clk) begin
    if (reset) begin
      resp <= '0;
    end else if (fix) begin
      resp <= resp_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/int_div_iterative.sv
/*
  Iterative 32-bit divider, valid-ready request and response.
  Response valid 34 cycles after the request handshake; one op at a time.
*/
`timescale 1ns/100ps
`default_nettype none

module int_div_iterative (
  input  logic               clk,
  input  logic               reset,
  input  div_pkg::div_req_t  req,
  input  logic               req_val,
  output logic               req_rdy,
  output div_pkg::div_resp_t resp,
  output logic               resp_val,
  input  logic               resp_rdy
);

  // ----------------------------------------
  // strobes from the controller
  // ----------------------------------------
  logic capture;
  logic load;
  logic step;
  logic fix;
  logic last_step;

  // datapath between blocks
  div_pkg::div_operands_t     ops;
  logic [div_pkg::data_w-1:0] quot_mag;
  logic [div_pkg::data_w-1:0] rem_mag;

  div_ctrl ctrl0 (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .resp_rdy  (resp_rdy),
    .last_step (last_step),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .capture   (capture),
    .load      (load),
    .step      (step),
    .fix       (fix)
  );

  // restarted by load
  div_step_counter cnt0 (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .step      (step),
    .last_step (last_step)
  );

  div_operand_prep prep0 (
    .clk     (clk),
    .reset   (reset),
    .capture (capture),
    .req     (req),
    .ops     (ops)
  );

  div_shift_sub core0 (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .step     (step),
    .ops      (ops),
    .quot_mag (quot_mag),
    .rem_mag  (rem_mag)
  );

  div_result_fix fix0 (
    .clk      (clk),
    .reset    (reset),
    .fix      (fix),
    .ops      (ops),
    .quot_mag (quot_mag),
    .rem_mag  (rem_mag),
    .resp     (resp)
  );

endmodule

`default_nettype wire

// File: bench/int_div_assert.sv
/*
  Handshake and latency checks, bound into int_div_iterative.
  Failures are tallied in fail_cnt, read by the testbench summary.
*/
`timescale 1ns/100ps
`default_nettype none

module int_div_assert (
  input logic               clk,
  input logic               reset,
  input logic               req_val,
  input logic               req_rdy,
  input logic               resp_val,
  input logic               resp_rdy,
  input div_pkg::div_resp_t resp
);

  int unsigned fail_cnt = 0;

  // idle and done never overlap
  no_overlap: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
  else begin
    fail_cnt++;
    $error("req_rdy and resp_val were high together");
  end

  // response held under back-pressure
  resp_held: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp))
  else begin
    fail_cnt++;
    $error("response changed or dropped before resp_rdy");
  end

  // rise seen one edge after it happened, so latency plus one
  resp_timing: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> $past(req_val && req_rdy, div_pkg::resp_latency + 1))
  else begin
    fail_cnt++;
    $error("resp_val rose at the wrong distance from the request handshake");
  end

endmodule

bind int_div_iterative int_div_assert assert0 (
  .clk      (clk),
  .reset    (reset),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy),
  .resp     (resp)
);

`default_nettype wire

// File: bench/int_div_tb.sv
/*
  Testbench for int_div_iterative: corner ops in both modes, then random.
  One division in flight; resp_rdy held back 0 to 7 cycles per response.
*/
`timescale 1ns/100ps
`default_nettype none

module int_div_tb;

  localparam int unsigned n_ops       = 400;
  localparam int unsigned clk_half_ns = 50;
  // worst case per op is about 43 cycles, plus reset and slack
  localparam int unsigned timeout_ns  = (n_ops * (div_pkg::resp_latency + 10) + 200) * 100;

  logic               clk;
  logic               reset;
  div_pkg::div_req_t  req;
  logic               req_val;
  logic               req_rdy;
  div_pkg::div_resp_t resp;
  logic               resp_val;
  logic               resp_rdy;

  div_pkg::div_req_t  ops_q[$];
  // accepted requests awaiting their response
  div_pkg::div_req_t  exp_q[$];
  int unsigned        start_q[$];
  int unsigned        cycle_cnt;
  int unsigned        resp_cnt;
  int unsigned        value_errs;
  int unsigned        proto_errs;
  logic               resp_val_prev;

  int_div_iterative dut0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clk_half_ns) clk = ~clk;
    end
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic div_pkg::div_resp_t expected_result(div_pkg::div_req_t r);
    logic                       sgn;
    logic                       a_neg;
    logic                       b_neg;
    logic [div_pkg::data_w-1:0] a_abs;
    logic [div_pkg::data_w-1:0] b_abs;
    logic [div_pkg::data_w-1:0] q_abs;
    logic [div_pkg::data_w-1:0] r_abs;
    div_pkg::div_resp_t         res;
    sgn   = (r.fn == div_pkg::div_fn_signed);
    a_neg = sgn && r.a[div_pkg::data_w-1];
    b_neg = sgn && r.b[div_pkg::data_w-1];
    a_abs = a_neg ? -r.a : r.a;
    b_abs = b_neg ? -r.b : r.b;
    if (b_abs == '0) begin
      // no trap: all-ones quotient, dividend kept as remainder
      q_abs = '1;
      r_abs = a_abs;
    end else begin
      q_abs = a_abs / b_abs;
      r_abs = a_abs % b_abs;
    end
    // truncate toward zero, remainder takes dividend sign
    res.quot = (a_neg != b_neg) ? -q_abs : q_abs;
    res.rem  = a_neg ? -r_abs : r_abs;
    return res;
  endfunction

  function automatic div_pkg::div_req_t make_op(div_pkg::div_fn_e fn,
                                                logic [div_pkg::data_w-1:0] a,
                                                logic [div_pkg::data_w-1:0] b);
    div_pkg::div_req_t r;
    r.fn = fn;
    r.a  = a;
    r.b  = b;
    return r;
  endfunction

  // corner grid in both modes, then random fill
  task automatic build_ops();
    logic [div_pkg::data_w-1:0] corner [9];
    logic [div_pkg::data_w-1:0] a;
    logic [div_pkg::data_w-1:0] b;
    int unsigned                sh;
    div_pkg::div_fn_e           fn;
    corner = '{32'h0000_0000, 32'h0000_0001, 32'h0000_0002, 32'h0000_0007, 32'h7fff_ffff,
               32'h8000_0000, 32'hffff_fffe, 32'hffff_fff9, 32'hffff_ffff};
    for (int f = 0; f < 2; f++) begin
      for (int i = 0; i < 9; i++) begin
        for (int j = 0; j < 9; j++) begin
          ops_q.push_back(make_op(div_pkg::div_fn_e'(f[0]), corner[i], corner[j]));
        end
      end
    end
    while (ops_q.size() < n_ops) begin
      fn = div_pkg::div_fn_e'(1'($urandom));
      a  = $urandom;
      b  = $urandom;
      // shrink the divisor by a random amount, quotients of all sizes
      sh = $urandom_range(31, 0);
      b  = b >> sh;
      ops_q.push_back(make_op(fn, a, b));
    end
  endtask

  // ----------------------------------------
  // comparison process
  // ----------------------------------------
  always @(posedge clk) begin : monitor
    div_pkg::div_req_t  cur;
    div_pkg::div_resp_t want;
    int unsigned        lat;
    if (reset) begin
      cycle_cnt     = 0;
      resp_val_prev = 1'b0;
    end else begin
      cycle_cnt++;
      if (exp_q.size() != 0) begin
        assert (!req_rdy) else begin
          proto_errs++;
          $display("req_rdy went high while a division was still in flight");
        end
      end else begin
        assert (!resp_val) else begin
          proto_errs++;
          $display("resp_val went high with no request outstanding");
        end
      end
      // resp_val rose on the previous edge
      if (resp_val && !resp_val_prev && exp_q.size() != 0) begin
        lat = cycle_cnt - 1 - start_q[0];
        assert (lat == div_pkg::resp_latency) else begin
          proto_errs++;
          $display("error: resp_val latency got %h expected %h", lat, div_pkg::resp_latency);
        end
      end
      if (resp_val && resp_rdy && exp_q.size() != 0) begin
        cur  = exp_q.pop_front();
        void'(start_q.pop_front());
        want = expected_result(cur);
        resp_cnt++;
        assert (resp.quot == want.quot) else begin
          value_errs++;
          $display("error: resp.quot got %h expected %h (fn %0d a %h b %h)",
                   resp.quot, want.quot, cur.fn, cur.a, cur.b);
        end
        assert (resp.rem == want.rem) else begin
          value_errs++;
          $display("error: resp.rem got %h expected %h (fn %0d a %h b %h)",
                   resp.rem, want.rem, cur.fn, cur.a, cur.b);
        end
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(req);
        start_q.push_back(cycle_cnt);
      end
      resp_val_prev = resp_val;
    end
  end

  // ----------------------------------------
  // stimulus, falling edge
  // ----------------------------------------
  initial begin
    int unsigned idx;
    int unsigned hold;
    reset      = 1'b1;
    req        = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    value_errs = 0;
    proto_errs = 0;
    resp_cnt   = 0;
    void'($urandom(32'h6616ff64));
    build_ops();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    assert (req_rdy && !resp_val) else begin
      proto_errs++;
      $display("after reset req_rdy is not high or resp_val is not low");
    end

    idx     = 0;
    req     = ops_q[0];
    req_val = 1'b1;
    while (idx < n_ops) begin
      // taken on the first edge that sees req_rdy
      do begin
        @(posedge clk);
      end while (!req_rdy);
      @(negedge clk);
      req_val = 1'b0;
      // junk payload once taken, the divider must not care
      req.fn  = div_pkg::div_fn_e'(1'($urandom));
      req.a   = $urandom;
      req.b   = $urandom;
      do begin
        @(negedge clk);
      end while (!resp_val);
      hold = $urandom_range(7, 0);
      repeat (hold) @(negedge clk);
      resp_rdy = 1'b1;
      idx++;
      // next request waits during the response handshake
      if (idx < n_ops) begin
        req     = ops_q[idx];
        req_val = 1'b1;
      end
      @(negedge clk);
      resp_rdy = 1'b0;
    end

    repeat (3) @(negedge clk);
    assert (resp_cnt == n_ops && exp_q.size() == 0) else begin
      proto_errs++;
      $display("only %0d of %0d responses were checked", resp_cnt, n_ops);
    end
    $display("summary: %0d responses, %0d value errors, %0d protocol errors, %0d assertion failures",
             resp_cnt, value_errs, proto_errs, dut0.assert0.fail_cnt);
    if (value_errs + proto_errs + dut0.assert0.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(timeout_ns);
    $display("watchdog: run did not finish within %0d ns, the divider appears hung",
             timeout_ns);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hw/div_pkg.sv
hw/div_ctrl.sv
hw/div_step_counter.sv
hw/div_operand_prep.sv
hw/div_shift_sub.sv
hw/div_result_fix.sv
hw/int_div_iterative.sv
bench/int_div_assert.sv
bench/int_div_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the divider testbench with Verilator and run it.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module int_div_tb \
  --Mdir obj_dir -o int_div_sim \
  -f flist.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# keep running past assertion errors so the testbench prints its own summary
sim_out=$(./obj_dir/int_div_sim +verilator+error+limit+1000 2>&1)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
